/* files.f */
+incdir+hdl
hdl/uart_rx_pkg.sv
hdl/uart_rx.sv
hdl/rx_channel_port.sv
hdl/rx_arbiter.sv
hdl/rx_fifo.sv
hdl/uart_rx_hub.sv
testbench/tb_clk_gen.sv
testbench/tb_uart_rx_hub.sv

/* Bender.yml */
package:
  name: uart_rx_hub

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_rx_pkg.sv
      - hdl/uart_rx.sv
      - hdl/rx_channel_port.sv
      - hdl/rx_arbiter.sv
      - hdl/rx_fifo.sv
      - hdl/uart_rx_hub.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_uart_rx_hub.sv

/* testbench/tb_uart_rx_hub.sv */
//----------------------------------------
// testbench for the two-line receive hub
// table rows become serial frames, a host
// process pops and checks entries against
// per-line expected queues
//----------------------------------------

`timescale 1ns/1ns

`include "uart_rx_defines.svh"

module tb_uart_rx_hub;

  localparam int BIT_CYC   = 2 * `UART_HALF_BIT;
  localparam int FRAME_CYC = 10 * BIT_CYC;
  localparam int NUM_TESTS = 5;

  // one serial frame per row
  typedef struct {
    int                    test;
    int                    line;
    uart_rx_pkg::rx_byte_t data;
    bit                    stop;
    int                    offset;
    bit                    pop_en;
  } row_t;

  logic                    clk;
  logic                    nrst;
  uart_rx_pkg::line_mask_t rxd;
  logic                    rd_pop;
  logic                    rd_valid;
  uart_rx_pkg::rx_entry_t  rd_entry;
  uart_rx_pkg::line_mask_t frame_err;
  uart_rx_pkg::line_mask_t overrun;

  row_t                    rows[$];
  uart_rx_pkg::rx_entry_t  exp_q0[$];
  uart_rx_pkg::rx_entry_t  exp_q1[$];
  uart_rx_pkg::line_mask_t exp_ferr;
  uart_rx_pkg::line_mask_t exp_ovr;
  // reference view of bytes parked in the ports while the FIFO is full
  uart_rx_pkg::line_mask_t held;
  int fifo_cnt;
  bit pop_en;
  int kept_cnt;
  int popped_cnt;
  int err_cnt;
  int test_errs;
  int pass_cnt;
  int fail_cnt;
  int limit_cycles = 0;

  tb_clk_gen u_clk (
    .clk(clk),
    .nrst(nrst)
  );

  uart_rx_hub u_dut (
    .clk(clk), .nrst(nrst), .rxd(rxd), .rd_pop(rd_pop), .rd_valid(rd_valid),
    .rd_entry(rd_entry), .frame_err(frame_err), .overrun(overrun)
  );

  // ---------------------------------------
  // stimulus table
  // ---------------------------------------
  task automatic add_row(int test, int line, uart_rx_pkg::rx_byte_t data, bit stop,
                         int offset, bit pop);
    rows.push_back('{test, line, data, stop, offset, pop});
  endtask

  task automatic build_table();
    // single frame per line, line 1 after line 0 is done
    add_row(0, 0, 8'hA5, 1'b1, 0, 1'b1);
    add_row(0, 1, 8'h3C, 1'b1, FRAME_CYC + 20, 1'b1);
    // both lines at once, two frames each
    add_row(1, 0, 8'h11, 1'b1, 0, 1'b1);
    add_row(1, 1, 8'h81, 1'b1, 0, 1'b1);
    add_row(1, 0, 8'h22, 1'b1, 0, 1'b1);
    add_row(1, 1, 8'h42, 1'b1, 3, 1'b1);
    // low stop bit on line 1, good frame on line 0
    add_row(2, 1, 8'h5A, 1'b0, 0, 1'b1);
    add_row(2, 0, 8'h99, 1'b1, 7, 1'b1);
    // host stalled, line 0 overfills its port
    for (int i = 0; i < 8; i++) begin
      add_row(3, 0, uart_rx_pkg::rx_byte_t'($urandom), 1'b1, 0, 1'b0);
    end
    for (int i = 0; i < 5; i++) begin
      add_row(3, 1, uart_rx_pkg::rx_byte_t'($urandom), 1'b1, 0, 1'b0);
    end
    // back to back on line 1, single stop bits
    add_row(4, 1, 8'h01, 1'b1, 0, 1'b1);
    add_row(4, 1, 8'h80, 1'b1, 0, 1'b1);
    add_row(4, 1, 8'hFF, 1'b1, 0, 1'b1);
    add_row(4, 1, 8'h00, 1'b1, 0, 1'b1);
  endtask

  function automatic bit test_pop(int t);
    foreach (rows[i]) begin
      if (rows[i].test == t) return rows[i].pop_en;
    end
    return 1'b1;
  endfunction

  // all tasks start and end 1 ns after a rising edge
  task automatic wait_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // start bit, 8 data bits LSB first, stop bit
  task automatic drive_frame(int line, uart_rx_pkg::rx_byte_t data, bit stop);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd[line] = bits[i];
      wait_cycles(BIT_CYC);
    end
    rxd[line] = 1'b1;
  endtask

  // expected outcome of one frame, decided when it starts
  task automatic predict(row_t r);
    if (!r.stop) begin
      exp_ferr[r.line] = 1'b1;
    end else if (held[r.line]) begin
      exp_ovr[r.line] = 1'b1;
    end else begin
      kept_cnt++;
      if (r.line == 0) exp_q0.push_back({1'b0, r.data});
      else exp_q1.push_back({1'b1, r.data});
      // no pops, so space runs out and the port keeps the next one
      if (!pop_en) begin
        if (fifo_cnt < `UART_FIFO_DEPTH) fifo_cnt++;
        else held[r.line] = 1'b1;
      end
    end
  endtask

  task automatic drive_line(int line, int t);
    foreach (rows[i]) begin
      if (rows[i].test == t && rows[i].line == line) begin
        wait_cycles(rows[i].offset);
        predict(rows[i]);
        drive_frame(line, rows[i].data, rows[i].stop);
      end
    end
  endtask

  // ---------------------------------------
  // compare tasks
  // ---------------------------------------
  task automatic check_entry(string name, uart_rx_pkg::rx_entry_t got,
                             uart_rx_pkg::rx_entry_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic check_flags(string name, uart_rx_pkg::line_mask_t got,
                             uart_rx_pkg::line_mask_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic note_failure(string msg);
    $display("failure at %0t ns: %s", $time, msg);
    err_cnt++;
    test_errs++;
  endtask

  // entry tag picks the queue it is checked against
  task automatic check_popped(uart_rx_pkg::rx_entry_t got);
    popped_cnt++;
    if (got[8] === 1'b0 && exp_q0.size() > 0) check_entry("rd_entry", got, exp_q0.pop_front());
    else if (got[8] === 1'b1 && exp_q1.size() > 0) check_entry("rd_entry", got, exp_q1.pop_front());
    else note_failure("host read an entry that no frame accounts for");
  endtask

  // ---------------------------------------
  // host side, one pop per cycle while enabled
  // ---------------------------------------
  initial begin
    rd_pop = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (pop_en && rd_valid === 1'b1) begin
        check_popped(rd_entry);
        rd_pop = 1'b1;
      end else begin
        rd_pop = 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int gap;
    int limit;
    rxd        = '1;
    exp_ferr   = '0;
    exp_ovr    = '0;
    held       = '0;
    fifo_cnt   = 0;
    pop_en     = 1'b0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    kept_cnt   = 0;
    popped_cnt = 0;
    gap        = $urandom(47727);
    build_table();
    // every frame in series plus per-test gap and drain slack
    limit = 500 + NUM_TESTS * 400;
    foreach (rows[i]) limit += rows[i].offset + FRAME_CYC;
    limit_cycles = limit;
    wait (nrst === 1'b1);
    wait_cycles(1);
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errs  = 0;
      kept_cnt   = 0;
      popped_cnt = 0;
      gap = 20 + ($urandom % 40);
      wait_cycles(gap);
      pop_en = test_pop(t);
      fork
        drive_line(0, t);
        drive_line(1, t);
      join
      // last entries settle, a stalled host resumes once both lines are quiet
      wait_cycles(BIT_CYC);
      pop_en = 1'b1;
      // host drains until the FIFO runs empty
      while (rd_valid === 1'b1) wait_cycles(1);
      wait_cycles(BIT_CYC);
      fifo_cnt = 0;
      held     = '0;
      if (rd_valid !== 1'b0) note_failure("FIFO still holds entries after all expected reads");
      if (popped_cnt != kept_cnt) note_failure("number of entries read differs from frames kept");
      if (!test_pop(t) && popped_cnt != `UART_FIFO_DEPTH + `UART_NUM_LINES) begin
        note_failure("stalled host did not get FIFO depth plus one byte per port");
      end
      // entries that never came must not shift the next test
      exp_q0.delete();
      exp_q1.delete();
      check_flags("frame_err", frame_err, exp_ferr);
      check_flags("overrun", overrun, exp_ovr);
      if (test_errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("test %0d: %s, %0d entries read", t, (test_errs == 0) ? "pass" : "fail",
               popped_cnt);
    end
    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/tb_clk_gen.sv */
//----------------------------------------
// testbench clock and reset source
// 4 ns clock, nrst low for 3 cycles
//----------------------------------------

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic nrst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release just after the third rising edge
  initial begin
    nrst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    nrst = 1'b1;
  end

endmodule

/* hdl/uart_rx_hub.sv */
//----------------------------------------
// two-line serial receive hub top level
// receivers feed channel ports, arbiter
// merges them into one FIFO for the host
//----------------------------------------

`timescale 1ns/1ns

`include "uart_rx_defines.svh"

module uart_rx_hub (
  input  logic                    clk,
  input  logic                    nrst,
  input  uart_rx_pkg::line_mask_t rxd,
  input  logic                    rd_pop,
  output logic                    rd_valid,
  output uart_rx_pkg::rx_entry_t  rd_entry,
  output uart_rx_pkg::line_mask_t frame_err,
  output uart_rx_pkg::line_mask_t overrun
);

  uart_rx_pkg::rx_byte_t   rx_data [`UART_NUM_LINES];
  uart_rx_pkg::rx_byte_t   port_data [`UART_NUM_LINES];
  uart_rx_pkg::line_mask_t rx_done;
  uart_rx_pkg::line_mask_t rx_err;
  uart_rx_pkg::line_mask_t req;
  uart_rx_pkg::line_mask_t ack;
  uart_rx_pkg::rx_entry_t  push_entry;
  logic push;
  logic full;

  // ---------------------------------------
  // one receiver and port per line
  // ---------------------------------------
  for (genvar i = 0; i < `UART_NUM_LINES; i++) begin : g_line
    uart_rx u_rx (
      .clk(clk), .nrst(nrst), .rxd(rxd[i]), .rx_data(rx_data[i]),
      .rx_busy(), .rx_done(rx_done[i]), .rx_err(rx_err[i])
    );
    rx_channel_port u_port (
      .clk(clk), .nrst(nrst), .rx_data(rx_data[i]), .rx_done(rx_done[i]),
      .rx_err(rx_err[i]), .req(req[i]), .ack(ack[i]), .data(port_data[i]),
      .frame_err(frame_err[i]), .overrun(overrun[i])
    );
  end

  rx_arbiter u_arb (
    .clk(clk), .nrst(nrst), .req(req), .data0(port_data[0]), .data1(port_data[1]),
    .ack(ack), .full(full), .push(push), .push_entry(push_entry)
  );

  rx_fifo u_fifo (
    .clk(clk), .nrst(nrst), .push(push), .push_entry(push_entry), .full(full),
    .rd_pop(rd_pop), .rd_valid(rd_valid), .rd_entry(rd_entry)
  );

endmodule

/* hdl/rx_fifo.sv */
//----------------------------------------
// shared receive FIFO of tagged entries
// arbiter pushes, host pops, rd_valid
// means not empty
//----------------------------------------

`timescale 1ns/1ns

`include "uart_rx_defines.svh"

module rx_fifo (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   push,
  input  uart_rx_pkg::rx_entry_t push_entry,
  output logic                   full,
  input  logic                   rd_pop,
  output logic                   rd_valid,
  output uart_rx_pkg::rx_entry_t rd_entry
);

  uart_rx_pkg::rx_entry_t mem [`UART_FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [`UART_FIFO_AW:0] wr_ptr;
  logic [`UART_FIFO_AW:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  // pop on an empty FIFO is ignored
  assign do_pop  = rd_pop && rd_valid;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage array
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr[`UART_FIFO_AW-1:0]] <= push_entry;
  end

  // same address, wrap bits differ -> full
  assign full = (wr_ptr[`UART_FIFO_AW] != rd_ptr[`UART_FIFO_AW]) &&
                (wr_ptr[`UART_FIFO_AW-1:0] == rd_ptr[`UART_FIFO_AW-1:0]);
  assign rd_valid = (wr_ptr != rd_ptr);
  assign rd_entry = mem[rd_ptr[`UART_FIFO_AW-1:0]];

endmodule

/* hdl/rx_arbiter.sv */
//----------------------------------------
// round-robin arbiter between channel
// ports, grants one line at a time and
// pushes a tagged entry into the FIFO
//----------------------------------------

`timescale 1ns/1ns

`include "uart_rx_defines.svh"

module rx_arbiter (
  input  logic                    clk,
  input  logic                    nrst,
  input  uart_rx_pkg::line_mask_t req,
  input  uart_rx_pkg::rx_byte_t   data0,
  input  uart_rx_pkg::rx_byte_t   data1,
  output uart_rx_pkg::line_mask_t ack,
  input  logic                    full,
  output logic                    push,
  output uart_rx_pkg::rx_entry_t  push_entry
);

  uart_rx_pkg::arb_state_t state;
  uart_rx_pkg::line_id_t   ptr;
  uart_rx_pkg::line_id_t   gnt;
  uart_rx_pkg::line_id_t   pick;
  uart_rx_pkg::rx_byte_t   gnt_data;
  logic                    any_req;

  // first requester at or after the pointer
  always_comb begin
    uart_rx_pkg::line_id_t idx;
    pick    = ptr;
    any_req = 1'b0;
    for (int i = 0; i < `UART_NUM_LINES; i++) begin
      idx = uart_rx_pkg::line_id_t'(ptr + i);
      if (!any_req && req[idx]) begin
        pick    = idx;
        any_req = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= uart_rx_pkg::SCAN;
      ptr   <= '0;
      gnt   <= '0;
    end else begin
      case (state)
        uart_rx_pkg::SCAN: begin
          if (any_req) begin
            gnt   <= pick;
            state <= uart_rx_pkg::ACK;
          end
        end
        // wait here while the FIFO is full
        uart_rx_pkg::ACK: begin
          if (!full) state <= uart_rx_pkg::RELEASE;
        end
        uart_rx_pkg::RELEASE: begin
          if (!req[gnt]) begin
            ptr   <= gnt + 1'b1;
            state <= uart_rx_pkg::SCAN;
          end
        end
        default: state <= uart_rx_pkg::SCAN;
      endcase
    end
  end

  assign gnt_data   = (gnt == uart_rx_pkg::line_id_t'(1)) ? data1 : data0;
  assign push       = (state == uart_rx_pkg::ACK) && !full;
  assign push_entry = {gnt, gnt_data};
  // ack rises with the push and holds until req drops
  assign ack = (push || (state == uart_rx_pkg::RELEASE)) ?
               (uart_rx_pkg::line_mask_t'(1) << gnt) : '0;

endmodule

/* hdl/rx_channel_port.sv */
//----------------------------------------
// one-byte holding register per line
// offers the byte to the arbiter over a
// four-phase req/ack and keeps sticky
// framing and overrun flags
//----------------------------------------

`timescale 1ns/1ns

module rx_channel_port (
  input  logic                  clk,
  input  logic                  nrst,
  input  uart_rx_pkg::rx_byte_t rx_data,
  input  logic                  rx_done,
  input  logic                  rx_err,
  output logic                  req,
  input  logic                  ack,
  output uart_rx_pkg::rx_byte_t data,
  output logic                  frame_err,
  output logic                  overrun
);

  uart_rx_pkg::port_state_t state;

  // handshake FSM
  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= uart_rx_pkg::EMPTY;
    end else begin
      case (state)
        uart_rx_pkg::EMPTY: begin
          if (rx_done) state <= uart_rx_pkg::REQ;
        end
        uart_rx_pkg::REQ: begin
          // arbiter took the byte, drop req next
          if (ack) state <= uart_rx_pkg::WAIT_ACK_LOW;
        end
        uart_rx_pkg::WAIT_ACK_LOW: begin
          if (!ack) state <= uart_rx_pkg::EMPTY;
        end
        default: state <= uart_rx_pkg::EMPTY;
      endcase
    end
  end

  // byte only loads into an empty port
  always_ff @(posedge clk) begin
    if ((state == uart_rx_pkg::EMPTY) && rx_done) data <= rx_data;
  end

  // sticky error flags, cleared by reset only
  always_ff @(posedge clk) begin
    if (!nrst) begin
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (rx_err) frame_err <= 1'b1;
      // new byte while still holding one is lost
      if (rx_done && (state != uart_rx_pkg::EMPTY)) overrun <= 1'b1;
    end
  end

  assign req = (state == uart_rx_pkg::REQ);

endmodule

/* hdl/uart_rx.sv */
//----------------------------------------
// 8N1 receiver for one asynchronous line
// samples each bit at its middle, pulses
// rx_done on a good stop bit or rx_err on
// a low one, rx_data valid with rx_done
//----------------------------------------

`timescale 1ns/1ns

`include "uart_rx_defines.svh"

module uart_rx (
  input  logic                clk,
  input  logic                nrst,
  input  logic                rxd,
  output uart_rx_pkg::rx_byte_t rx_data,
  output logic                rx_busy,
  output logic                rx_done,
  output logic                rx_err
);

  uart_rx_pkg::rx_state_t state;
  uart_rx_pkg::baud_cnt_t cnt;
  logic [2:0] bit_cnt;

  // two-flop synchronizer plus one more for edge detect
  logic rxd_m;
  logic rxd_s;
  logic rxd_q;
  logic start;
  logic sample;

  // idle line is high, so all stages come out of reset high
  always_ff @(posedge clk) begin
    if (!nrst) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
      rxd_q <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
      rxd_q <= rxd_s;
    end
  end

  // falling edge of the synchronized line
  assign start = rxd_q & ~rxd_s;
  // countdown expired, take a sample this cycle
  assign sample = (cnt == '0);

  // ---------------------------------------
  // frame FSM
  // ---------------------------------------
  always_ff @(posedge clk) begin
    if (!nrst) begin
      state   <= uart_rx_pkg::IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_rx_pkg::IDLE: begin
          if (start) begin
            // 1.5 bits from start edge to middle of bit 0
            cnt     <= uart_rx_pkg::baud_cnt_t'(3 * `UART_HALF_BIT - 1);
            bit_cnt <= '0;
            state   <= uart_rx_pkg::DATA;
          end
        end
        uart_rx_pkg::DATA: begin
          if (sample) begin
            cnt     <= uart_rx_pkg::baud_cnt_t'(2 * `UART_HALF_BIT - 1);
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= uart_rx_pkg::STOP;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        uart_rx_pkg::STOP: begin
          // back to idle right at the stop sample
          if (sample) begin
            state <= uart_rx_pkg::IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= uart_rx_pkg::IDLE;
      endcase
    end
  end

  // data shift register, LSB arrives first
  always_ff @(posedge clk) begin
    if ((state == uart_rx_pkg::DATA) && sample) begin
      rx_data <= {rxd_s, rx_data[7:1]};
    end
  end

  assign rx_busy = (state != uart_rx_pkg::IDLE);
  // strobes come straight off the stop sample
  assign rx_done = (state == uart_rx_pkg::STOP) && sample && rxd_s;
  assign rx_err  = (state == uart_rx_pkg::STOP) && sample && !rxd_s;

endmodule

/* hdl/uart_rx_pkg.sv */
//----------------------------------------
// shared vector types and FSM encodings
// for the receive hub, referenced by
// scoped name from every module
//----------------------------------------

`include "uart_rx_defines.svh"

package uart_rx_pkg;

  // payload and tagging
  typedef logic [7:0] rx_byte_t;
  typedef logic [0:0] line_id_t;
  typedef logic [`UART_NUM_LINES-1:0] line_mask_t;

  // FIFO entry, line number on top of the byte
  typedef logic [8:0] rx_entry_t;

  // mid-bit sample countdown
  typedef logic [15:0] baud_cnt_t;

  // ---------------------------------------
  // state encodings
  // ---------------------------------------
  typedef enum logic [1:0] {IDLE, DATA, STOP} rx_state_t;
  typedef enum logic [1:0] {EMPTY, REQ, WAIT_ACK_LOW} port_state_t;
  typedef enum logic [1:0] {SCAN, ACK, RELEASE} arb_state_t;

endpackage

/* hdl/uart_rx_defines.svh */
//----------------------------------------
// fixed build constants for the receive hub
// include wherever a rate, line count or
// FIFO size is needed
//----------------------------------------

`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

// system clock in Hz
`define UART_CLK_HZ 250000000

// serial line rate, 8N1 only
`define UART_BAUD 25000000

// half a bit period in clock cycles
`define UART_HALF_BIT ((`UART_CLK_HZ / `UART_BAUD) / 2)

// number of serial lines into the hub
`define UART_NUM_LINES 2

// shared FIFO size, depth must be a power of two
`define UART_FIFO_DEPTH 8
`define UART_FIFO_AW 3

`endif
